/* hdl/eeprom_config.svh */
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// CLK cycles per SCL half-period, 2 or more
`define EE_SCL_HALF 4

// device type code in the upper nibble of the control byte
`define EE_DEVICE_CODE 4'b1010

`endif

/* hdl/i2c_pkg.sv */
package i2c_pkg;

    // one byte as it travels on the bus
    typedef logic [7:0] byte_t;

    // CMD_START doubles as repeated start
    typedef enum logic [1:0]
    {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } i2c_cmd_e;

    typedef struct packed
    {
        i2c_cmd_e cmd;
        byte_t    data;    // byte to send, write only
    } i2c_req_t;

    typedef struct packed
    {
        byte_t data;       // received byte, read only
        logic  ack;        // slave pulled SDA low on the 9th clock
    } i2c_rsp_t;

endpackage

/* hdl/eeprom_pkg.sv */
package eeprom_pkg;

    typedef logic [10:0] ee_addr_t;   // 2048 bytes
    typedef logic [7:0]  ee_data_t;

    // random read goes START CTRL_W ADDR RESTART CTRL_R DATA_R STOP
    typedef enum logic [3:0]
    {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA_W,
        RESTART,
        CTRL_R,
        DATA_R,
        STOP,
        DONE
    } ee_state_e;

endpackage

/* hdl/i2c_bit_engine.sv */
`include "eeprom_config.svh"

module i2c_bit_engine
    import i2c_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  i2c_req_t req,
    input  logic     req_valid,
    output i2c_rsp_t rsp,
    output logic     rsp_done,
    output logic     scl,
    output logic     sda_oe,
    input  logic     sda_in
);

    localparam int HW = $clog2(`EE_SCL_HALF);
    localparam logic [HW-1:0] H_LAST = HW'(`EE_SCL_HALF - 1);
    localparam logic [HW-1:0] H_MID = HW'(`EE_SCL_HALF / 2);

    logic          active;
    i2c_cmd_e      cmd;
    logic [4:0]    phase;      // one step per SCL half-period
    logic [HW-1:0] hcnt;
    byte_t         shreg;
    logic          ack;
    logic          half_end;
    logic          last_phase;

    function automatic logic scl_level(i2c_cmd_e c, logic [4:0] p);
        case (c)
            CMD_START: return (p == 5'd1) || (p == 5'd2);
            CMD_STOP:  return p != 5'd0;
            default:   return p[0];    // low on even, high on odd
        endcase
    endfunction

    function automatic logic sda_pull(i2c_cmd_e c, logic [4:0] p, logic bit_out);
        case (c)
            CMD_START: return p >= 5'd2;
            CMD_STOP:  return p <= 5'd1;
            CMD_WRITE: return (p < 5'd16) && !bit_out;
            default:   return 1'b0;    // read leaves SDA released including the NACK
        endcase
    endfunction

    assign half_end = (hcnt == H_LAST);
    assign last_phase = (cmd == CMD_WRITE || cmd == CMD_READ) ? (phase == 5'd17)
                                                              : (phase == 5'd3);
    assign rsp = '{data: shreg, ack: ack};

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            phase    <= '0;
            hcnt     <= '0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
            rsp_done <= 1'b0;
        end
        else
        begin
            rsp_done <= 1'b0;
            if (!active)
            begin
                if (req_valid)
                begin
                    active <= 1'b1;
                    phase  <= '0;
                    hcnt   <= '0;
                    scl    <= scl_level(req.cmd, 5'd0);
                end
            end
            else
            begin
                // SDA moves one CLK after the SCL edge that opens the phase
                if (hcnt == '0)
                    sda_oe <= sda_pull(cmd, phase, shreg[7]);
                if (half_end)
                begin
                    hcnt <= '0;
                    if (last_phase)
                    begin
                        active   <= 1'b0;
                        rsp_done <= 1'b1;
                    end
                    else
                    begin
                        phase <= phase + 5'd1;
                        scl   <= scl_level(cmd, phase + 5'd1);
                    end
                end
                else
                    hcnt <= hcnt + HW'(1);
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && req_valid)
        begin
            cmd   <= req.cmd;
            shreg <= req.data;
            ack   <= 1'b0;
        end
        else if (active && phase[0] && phase < 5'd16)
        begin
            if (cmd == CMD_READ && hcnt == H_MID)
                shreg <= {shreg[6:0], sda_in};   // sample mid SCL high
            else if (cmd == CMD_WRITE && half_end)
                shreg <= {shreg[6:0], 1'b0};     // next bit to MSB as SCL falls
        end
        else if (active && cmd == CMD_WRITE && phase == 5'd17 && hcnt == H_MID)
            ack <= !sda_in;
    end

endmodule

/* hdl/eeprom_sequencer.sv */
`include "eeprom_config.svh"

module eeprom_sequencer
    import i2c_pkg::*, eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     wr,
    input  logic     rd,
    input  ee_addr_t addr,
    input  ee_data_t wr_data,
    output ee_data_t rd_data,
    output logic     done,
    output logic     nack,
    output logic     busy,
    output i2c_req_t req,
    output logic     req_valid,
    input  i2c_rsp_t rsp,
    input  logic     rsp_done
);

    ee_state_e state;
    ee_state_e next_ok;    // successor when the slave acked
    ee_addr_t  addr_q;
    ee_data_t  data_q;
    logic      is_rd;
    logic      issued;     // command with the engine, waiting for rsp_done
    i2c_req_t  cmd_req;
    logic      accept;
    logic      bus_state;

    assign accept = (state == IDLE) && (wr || rd);
    assign bus_state = (state != IDLE) && (state != DONE);

    always_comb
    begin
        case (state)
            START, RESTART: cmd_req = '{cmd: CMD_START, data: '0};
            CTRL_W: cmd_req = '{cmd: CMD_WRITE, data: {`EE_DEVICE_CODE, addr_q[10:8], 1'b0}};
            ADDR:   cmd_req = '{cmd: CMD_WRITE, data: addr_q[7:0]};
            DATA_W: cmd_req = '{cmd: CMD_WRITE, data: data_q};
            CTRL_R: cmd_req = '{cmd: CMD_WRITE, data: {`EE_DEVICE_CODE, addr_q[10:8], 1'b1}};
            DATA_R: cmd_req = '{cmd: CMD_READ, data: '0};
            default: cmd_req = '{cmd: CMD_STOP, data: '0};
        endcase
    end

    always_comb
    begin
        case (state)
            START:   next_ok = CTRL_W;
            CTRL_W:  next_ok = ADDR;
            ADDR:    next_ok = is_rd ? RESTART : DATA_W;
            RESTART: next_ok = CTRL_R;
            CTRL_R:  next_ok = DATA_R;
            DATA_W,
            DATA_R:  next_ok = STOP;
            STOP:    next_ok = DONE;
            default: next_ok = IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= IDLE;
            busy      <= 1'b0;
            done      <= 1'b0;
            nack      <= 1'b0;
            req_valid <= 1'b0;
            issued    <= 1'b0;
        end
        else
        begin
            req_valid <= 1'b0;
            done      <= 1'b0;
            if (accept)
            begin
                nack  <= 1'b0;
                busy  <= 1'b1;
                state <= START;
            end
            else if (state == DONE)
            begin
                done  <= 1'b1;
                busy  <= 1'b0;
                state <= IDLE;
            end
            else if (bus_state && !issued)
            begin
                req_valid <= 1'b1;
                issued    <= 1'b1;
            end
            else if (bus_state && rsp_done)
            begin
                issued <= 1'b0;
                if (req.cmd == CMD_WRITE && !rsp.ack)
                begin
                    nack  <= 1'b1;    // skip the rest, close the bus
                    state <= STOP;
                end
                else
                    state <= next_ok;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q <= addr;
            data_q <= wr_data;
            is_rd  <= !wr;        // write wins over read
        end
        if (bus_state && !issued)
            req <= cmd_req;
        if (state == DATA_R && issued && rsp_done)
            rd_data <= rsp.data;
    end

endmodule

/* hdl/eeprom_ctrl_top.sv */
module eeprom_ctrl_top
    import i2c_pkg::*, eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     wr,
    input  logic     rd,
    input  ee_addr_t addr,
    input  ee_data_t wr_data,
    output ee_data_t rd_data,
    output logic     done,
    output logic     nack,
    output logic     busy,
    output logic     scl,
    output logic     sda_oe,
    input  logic     sda_in
);

    i2c_req_t req;
    logic     req_valid;
    i2c_rsp_t rsp;
    logic     rsp_done;

    eeprom_sequencer seq0
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .rd_data   (rd_data),
        .done      (done),
        .nack      (nack),
        .busy      (busy),
        .req       (req),
        .req_valid (req_valid),
        .rsp       (rsp),
        .rsp_done  (rsp_done)
    );

    i2c_bit_engine eng0
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req       (req),
        .req_valid (req_valid),
        .rsp       (rsp),
        .rsp_done  (rsp_done),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

/* test/eeprom_model.sv */
`include "eeprom_config.svh"

module eeprom_model
    import i2c_pkg::*, eeprom_pkg::*;
(
    input  logic scl,
    input  logic sda,
    input  logic no_ack,
    output logic sda_pull,
    output logic violation
);
    timeunit 1ns;
    timeprecision 100ps;

    ee_data_t   mem [0:2047];
    logic       scl_q;
    logic       sda_q;
    logic       in_frame;
    logic [3:0] cnt;          // bits clocked in the current byte
    logic [1:0] byte_idx;     // control, address, data
    logic       reading;
    logic       read_next;
    logic       acking;
    logic [2:0] hi;
    byte_t      shreg;
    byte_t      rdsh;
    ee_addr_t   addr;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[ee_addr_t'(i)] = ee_data_t'(i) ^ ee_data_t'(i >> 3);
        scl_q = 1'b1;
        sda_q = 1'b1;
        in_frame = 1'b0;
        cnt = '0;
        sda_pull = 1'b0;
        violation = 1'b0;
    end

    always @(scl or sda)
    begin
        if (scl && scl_q && (sda != sda_q))
        begin
            // a legal start or stop sits in the first clock after a byte
            if (in_frame && cnt != 4'd1)
                violation = 1'b1;    // start or stop off a byte boundary
            in_frame = !sda;
            cnt = '0;
            byte_idx = '0;
            reading = 1'b0;
            read_next = 1'b0;
            acking = 1'b0;
        end
        else if (scl && !scl_q && in_frame)
        begin
            if (cnt < 4'd8)
            begin
                shreg = {shreg[6:0], sda};
                cnt = cnt + 4'd1;
                if (cnt == 4'd8 && reading)
                    acking = 1'b0;
                else if (cnt == 4'd8)
                begin
                    case (byte_idx)
                        2'd0:
                        begin
                            if (shreg[7:4] != `EE_DEVICE_CODE)
                                violation = 1'b1;
                            hi = shreg[3:1];
                            read_next = shreg[0];
                        end
                        2'd1: addr = {hi, shreg};
                        default: if (!no_ack) mem[addr] = shreg;
                    endcase
                    acking = !no_ack;
                    if (byte_idx != 2'd2)
                        byte_idx = byte_idx + 2'd1;
                end
            end
            else
            begin
                cnt = '0;    // ninth clock where a master NACK ends a read
                reading = 1'b0;
                if (read_next && acking)
                begin
                    reading = 1'b1;
                    rdsh = mem[addr];
                end
                read_next = 1'b0;
            end
        end
        else if (!scl && scl_q)
        begin
            if (!in_frame)
                sda_pull = 1'b0;
            else if (cnt == 4'd8)
                sda_pull = acking;
            else if (reading)
            begin
                sda_pull = !rdsh[7];
                rdsh = {rdsh[6:0], 1'b0};
            end
            else
                sda_pull = 1'b0;
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* test/tb_eeprom_ctrl.sv */
module tb_eeprom_ctrl
    import i2c_pkg::*, eeprom_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 4000;

    logic CLK, RESET, wr, rd, done, nack, busy, scl, sda_oe, sda, model_pull, no_ack, violation;
    ee_addr_t addr;
    ee_data_t wr_data, rd_data, q;
    ee_data_t ref_mem [0:2047];
    ee_addr_t addr_list [0:19];
    integer seed;
    int errors, timeouts, done_count, expected_dones;

    assign sda = !(sda_oe || model_pull);    // open-drain wire

    eeprom_ctrl_top dut0 (.CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr),
        .wr_data(wr_data), .rd_data(rd_data), .done(done), .nack(nack), .busy(busy),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda));

    eeprom_model mem0 (.scl(scl), .sda(sda), .no_ack(no_ack), .sda_pull(model_pull),
        .violation(violation));

    always #4 CLK = ~CLK;

    always @(negedge CLK)
        if (done)
            done_count++;

    task automatic check_value(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        assert (expv === actv)
        else
        begin
            errors++;
            $display("error %s: expected %0h, actual %0h", name, expv, actv);
        end
    endtask

    task automatic send_request(input logic w, input logic r, input ee_addr_t a,
                                input ee_data_t d);
        @(posedge CLK);
        #1;
        wr = w;
        rd = r;
        addr = a;
        wr_data = d;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
        check_value("busy after request", 1, 32'(busy));
    endtask

    task automatic wait_done(input logic exp_nack, input string name);
        int n;
        n = 0;
        @(negedge CLK);
        while (!done && n < WAIT_LIMIT)
        begin
            @(negedge CLK);
            n++;
        end
        if (!done)
        begin
            timeouts++;
            $display("timeout: no done pulse for %s", name);
        end
        q = rd_data;
        check_value({name, " nack"}, 32'(exp_nack), 32'(nack));
        check_value({name, " busy at done"}, 0, 32'(busy));
        expected_dones++;
        @(posedge CLK);
    endtask

    task automatic write_byte(input ee_addr_t a, input ee_data_t d);
        send_request(1'b1, 1'b0, a, d);
        wait_done(1'b0, "write");
        ref_mem[a] = d;
    endtask

    task automatic read_check(input ee_addr_t a, input string name);
        send_request(1'b0, 1'b1, a, '0);
        wait_done(1'b0, name);
        check_value(name, 32'(ref_mem[a]), 32'(q));
    endtask

    initial
    begin
        CLK = 1'b0;
        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wr_data = '0;
        no_ack = 1'b0;
        seed = 32'h3e309092;
        for (int i = 0; i < 2048; i++)
            ref_mem[ee_addr_t'(i)] = ee_data_t'(i) ^ ee_data_t'(i >> 3);
        repeat (4) @(posedge CLK);
        #1;
        RESET = 1'b0;
        @(negedge CLK);
        check_value("reset scl", 1, 32'(scl));
        check_value("reset sda_oe", 0, 32'(sda_oe));
        check_value("reset busy done nack", 0, 32'({busy, done, nack}));

        for (int i = 0; i < 20; i++)
        begin
            addr_list[i] = ee_addr_t'($random(seed));
            write_byte(addr_list[i], ee_data_t'($random(seed)));
        end
        for (int i = 0; i < 20; i++)
            read_check(addr_list[i], "random readback");

        // upper address bits ride in the control byte
        write_byte(11'h000, 8'h11);
        write_byte(11'h0ff, 8'h22);
        write_byte(11'h100, 8'h33);
        write_byte(11'h7ff, 8'h44);
        read_check(11'h000, "addr 000");
        read_check(11'h0ff, "addr 0ff");
        read_check(11'h100, "addr 100");
        read_check(11'h7ff, "addr 7ff");

        send_request(1'b0, 1'b1, addr_list[1], '0);
        repeat (20) @(posedge CLK);
        #1;
        wr = 1'b1;
        addr = addr_list[2];
        wr_data = ~ref_mem[addr_list[2]];
        @(posedge CLK);
        #1;
        wr = 1'b0;
        wait_done(1'b0, "read under ignored wr");
        check_value("read under ignored wr", 32'(ref_mem[addr_list[1]]), 32'(q));
        read_check(addr_list[2], "ignored wr memory");
        check_value("done pulse count", expected_dones, done_count);

        send_request(1'b1, 1'b1, addr_list[3], 8'h5a);
        wait_done(1'b0, "wr and rd together");
        ref_mem[addr_list[3]] = 8'h5a;
        read_check(addr_list[3], "wr wins");

        no_ack = 1'b1;
        send_request(1'b1, 1'b0, addr_list[0], ~ref_mem[addr_list[0]]);
        wait_done(1'b1, "write without ack");
        #1;
        no_ack = 1'b0;
        read_check(addr_list[0], "after missing ack");

        check_value("done pulse count", expected_dones, done_count);
        check_value("bus protocol violation", 0, 32'(violation));
        $display("errors %0d, timeouts %0d, done pulses %0d", errors, timeouts, done_count);
        if (errors == 0 && timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* files.f */
+incdir+hdl
hdl/i2c_pkg.sv
hdl/eeprom_pkg.sv
hdl/i2c_bit_engine.sv
hdl/eeprom_sequencer.sv
hdl/eeprom_ctrl_top.sv
test/eeprom_model.sv
test/tb_eeprom_ctrl.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_eeprom_ctrl -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "Result: PASSED" sim.log; then
    exit 0
else
    exit 1
fi
